//--- umi_aggregate.f
+incdir+include
rtl/umi_pkg.sv
rtl/umi_if.sv
rtl/umi_fifo.sv
rtl/umi_data_aggregator.sv
rtl/umi_aggregate_top.sv
bench/tb_umi_aggregate.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_umi_aggregate
FILELIST  := umi_aggregate.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_umi_aggregate.sv
`timescale 1ns/10ps
`include "umi_settings.svh"

module tb_umi_aggregate;

    localparam int NUM_MSGS = 80;
    localparam int BPF      = umi_pkg::BYTES_PER_FLIT;

    logic               clk;
    logic               nreset;
    logic               umi_in_valid;
    logic [`UMI_CW-1:0] umi_in_cmd;
    logic [`UMI_AW-1:0] umi_in_dstaddr;
    logic [`UMI_AW-1:0] umi_in_srcaddr;
    logic [`UMI_DW-1:0] umi_in_data;
    logic               umi_in_ready;
    logic               umi_out_valid;
    logic [`UMI_CW-1:0] umi_out_cmd;
    logic [`UMI_AW-1:0] umi_out_dstaddr;
    logic [`UMI_AW-1:0] umi_out_srcaddr;
    logic [`UMI_DW-1:0] umi_out_data;
    logic               umi_out_ready;

    integer seed;
    int     cycle_count;
    int     cycle_limit;
    logic   in_will_fire;

    // Input flits in send order
    umi_pkg::umi_cmd_u  stim_cmd_q [$];
    logic [`UMI_AW-1:0] stim_dst_q [$];
    logic [`UMI_AW-1:0] stim_src_q [$];
    logic [`UMI_DW-1:0] stim_data_q [$];

    // Expected messages and their byte stream
    umi_pkg::umi_cmd_u  msg_cmd_q [$];
    logic [`UMI_AW-1:0] msg_dst_q [$];
    logic [`UMI_AW-1:0] msg_src_q [$];
    logic [`UMI_DW-1:0] msg_data_q [$];
    bit                 msg_raw_q [$];
    int                 msg_rem_q [$];
    logic [7:0]         byte_q [$];

    umi_aggregate_top i_umi_aggregate_top (
        .clk             (clk),
        .nreset          (nreset),
        .umi_in_valid    (umi_in_valid),
        .umi_in_cmd      (umi_in_cmd),
        .umi_in_dstaddr  (umi_in_dstaddr),
        .umi_in_srcaddr  (umi_in_srcaddr),
        .umi_in_data     (umi_in_data),
        .umi_in_ready    (umi_in_ready),
        .umi_out_valid   (umi_out_valid),
        .umi_out_cmd     (umi_out_cmd),
        .umi_out_dstaddr (umi_out_dstaddr),
        .umi_out_srcaddr (umi_out_srcaddr),
        .umi_out_data    (umi_out_data),
        .umi_out_ready   (umi_out_ready)
    );

    always #20 clk = ~clk;

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input string act, input string exp);
        stop_on_failure($sformatf("Error at %0t: %s is %s, expected %s", $time, name, act, exp));
    endtask

    always @(posedge clk) begin
        if (cycle_limit > 0) begin
            cycle_count = cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                stop_on_failure($sformatf("Timeout after %0d cycles with flits still missing",
                                          cycle_count));
            end
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [4:0] pick_merge_opcode();
        case (rand_below(5))
            0: return umi_pkg::REQ_READ;
            1: return umi_pkg::REQ_WRITE;
            2: return umi_pkg::REQ_POSTED;
            3: return umi_pkg::REQ_RDMA;
            default: return umi_pkg::RESP_READ;
        endcase
    endfunction

    task automatic check_cmd(input string name, input umi_pkg::umi_cmd_u act,
                             input umi_pkg::umi_cmd_u exp);
        if (exp.req.opcode == umi_pkg::REQ_ATOMIC && act.atomic.atype !== exp.atomic.atype) begin
            report_mismatch({name, ".atype"}, $sformatf("%h", act.atomic.atype),
                            $sformatf("%h", exp.atomic.atype));
        end
        if (act !== exp) begin
            report_mismatch(name, $sformatf("%h", act), $sformatf("%h", exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [`UMI_AW-1:0] act,
                              input logic [`UMI_AW-1:0] exp);
        if (act !== exp) begin
            report_mismatch(name, $sformatf("%h", act), $sformatf("%h", exp));
        end
    endtask

    task automatic check_data(input string name, input logic [`UMI_DW-1:0] act,
                              input logic [`UMI_DW-1:0] exp, input int nbytes);
        logic [`UMI_DW-1:0] mask;
        int                 b;
        mask = '0;
        for (b = 0; b < nbytes && b < BPF; b++) begin
            mask[8*b +: 8] = 8'hff;
        end
        if ((act & mask) !== (exp & mask)) begin
            report_mismatch(name, $sformatf("%h", act & mask), $sformatf("%h", exp & mask));
        end
    endtask

    task automatic add_flit(input umi_pkg::umi_cmd_u cmd, input logic [`UMI_AW-1:0] dst,
                            input logic [`UMI_AW-1:0] src, input logic [`UMI_DW-1:0] data);
        stim_cmd_q.push_back(cmd);
        stim_dst_q.push_back(dst);
        stim_src_q.push_back(src);
        stim_data_q.push_back(data);
    endtask

    task automatic build_message();
        umi_pkg::umi_cmd_u  cmd;
        logic [`UMI_AW-1:0] dst;
        logic [`UMI_AW-1:0] src;
        logic [`UMI_DW-1:0] data;
        int                 nflits;
        int                 nbytes;
        int                 total;
        int                 i;
        int                 b;
        cmd  = $random(seed);
        dst  = {$random(seed), $random(seed)};
        src  = {$random(seed), $random(seed)};
        data = {$random(seed), $random(seed)};
        if (rand_below(4) == 0) begin
            // Lone flit that must bypass merging
            case (rand_below(3))
                0: cmd.req.opcode = umi_pkg::RESP_WRITE;
                1: cmd.req.opcode = umi_pkg::REQ_ATOMIC;
                default: begin
                    cmd.req.opcode = pick_merge_opcode();
                    cmd.req.ex     = 1'b1;
                end
            endcase
            cmd.req.eom = 1'b1;
            add_flit(cmd, dst, src, data);
            msg_cmd_q.push_back(cmd);
            msg_dst_q.push_back(dst);
            msg_src_q.push_back(src);
            msg_data_q.push_back(data);
            msg_raw_q.push_back(1'b1);
            msg_rem_q.push_back(0);
        end else begin
            cmd.req.opcode = pick_merge_opcode();
            cmd.req.size   = 3'(rand_below(4));
            cmd.req.ex     = 1'b0;
            nflits = 1 + rand_below(6);
            total  = 0;
            for (i = 0; i < nflits; i++) begin
                cmd.req.len = 8'(rand_below(BPF >> cmd.req.size));
                cmd.req.eom = (i == nflits - 1);
                if (i == 0) begin
                    msg_cmd_q.push_back(cmd);
                    msg_dst_q.push_back(dst);
                    msg_src_q.push_back(src);
                end
                nbytes = (int'(cmd.req.len) + 1) << cmd.req.size;
                for (b = 0; b < nbytes; b++) begin
                    byte_q.push_back(data[8*b +: 8]);
                end
                total = total + nbytes;
                add_flit(cmd, dst, src, data);
                dst  = {$random(seed), $random(seed)};
                src  = {$random(seed), $random(seed)};
                data = {$random(seed), $random(seed)};
            end
            msg_data_q.push_back('0);
            msg_raw_q.push_back(1'b0);
            msg_rem_q.push_back(total);
        end
    endtask

    task automatic drop_message();
        void'(msg_cmd_q.pop_front());
        void'(msg_dst_q.pop_front());
        void'(msg_src_q.pop_front());
        void'(msg_data_q.pop_front());
        void'(msg_raw_q.pop_front());
        void'(msg_rem_q.pop_front());
    endtask

    task automatic compare_output_flit();
        umi_pkg::umi_cmd_u  act_cmd;
        umi_pkg::umi_cmd_u  exp_cmd;
        logic [`UMI_DW-1:0] exp_data;
        int                 act_n;
        int                 exp_n;
        int                 b;
        act_cmd = umi_out_cmd;
        if (msg_cmd_q.size() == 0) begin
            stop_on_failure("Output flit appeared with no message left in the model");
        end
        exp_cmd = msg_cmd_q[0];
        check_addr("umi_out_dstaddr", umi_out_dstaddr, msg_dst_q[0]);
        check_addr("umi_out_srcaddr", umi_out_srcaddr, msg_src_q[0]);
        if (msg_raw_q[0]) begin
            check_cmd("umi_out_cmd", act_cmd, exp_cmd);
            check_data("umi_out_data", umi_out_data, msg_data_q[0], BPF);
            drop_message();
        end else begin
            act_n = (int'(act_cmd.req.len) + 1) << act_cmd.req.size;
            if (act_n > BPF) begin
                stop_on_failure("Output len describes more bytes than one flit can hold");
            end
            // Full flits first, remainder last
            exp_n = (msg_rem_q[0] > BPF) ? BPF : msg_rem_q[0];
            exp_cmd.req.len = 8'((exp_n >> exp_cmd.req.size) - 1);
            exp_cmd.req.eom = (exp_n == msg_rem_q[0]);
            check_cmd("umi_out_cmd", act_cmd, exp_cmd);
            exp_data = '0;
            for (b = 0; b < exp_n; b++) begin
                exp_data[8*b +: 8] = byte_q.pop_front();
            end
            check_data("umi_out_data", umi_out_data, exp_data, exp_n);
            msg_rem_q[0] = msg_rem_q[0] - exp_n;
            if (msg_rem_q[0] == 0) begin
                drop_message();
            end
        end
    endtask

    initial begin
        int i;
        int idx;
        seed           = 32'hdc89;
        clk            = 1'b0;
        nreset         = 1'b0;
        umi_in_valid   = 1'b0;
        umi_in_cmd     = '0;
        umi_in_dstaddr = '0;
        umi_in_srcaddr = '0;
        umi_in_data    = '0;
        umi_out_ready  = 1'b0;
        in_will_fire   = 1'b0;
        cycle_count    = 0;
        cycle_limit    = 0;
        for (i = 0; i < NUM_MSGS; i++) begin
            build_message();
        end
        cycle_limit = 40 * stim_cmd_q.size() + 100;

        repeat (3) begin
            @(negedge clk);
            if (umi_out_valid !== 1'b0) begin
                report_mismatch("umi_out_valid", $sformatf("%b", umi_out_valid), "0");
            end
        end
        nreset = 1'b1;

        idx = 0;
        while (idx < stim_cmd_q.size() || msg_cmd_q.size() != 0) begin
            @(negedge clk);
            if (in_will_fire) begin
                idx++;
            end
            umi_out_ready = (rand_below(10) >= 3);
            if (umi_out_valid && umi_out_ready) begin
                compare_output_flit();
            end
            // A flit that was not taken stays on the bus
            if (!(umi_in_valid && !in_will_fire)) begin
                if (idx < stim_cmd_q.size() && rand_below(8) != 0) begin
                    umi_in_valid   = 1'b1;
                    umi_in_cmd     = stim_cmd_q[idx];
                    umi_in_dstaddr = stim_dst_q[idx];
                    umi_in_srcaddr = stim_src_q[idx];
                    umi_in_data    = stim_data_q[idx];
                end else begin
                    umi_in_valid = 1'b0;
                end
            end
            in_will_fire = umi_in_valid && umi_in_ready;
        end

        // Any further flit would be a duplicate
        umi_in_valid = 1'b0;
        repeat (10) begin
            @(negedge clk);
            umi_out_ready = 1'b1;
            if (umi_out_valid) begin
                compare_output_flit();
            end
        end

        // Input FIFO drained back to empty
        if (umi_in_ready !== 1'b1) begin
            report_mismatch("umi_in_ready", $sformatf("%b", umi_in_ready), "1");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- rtl/umi_aggregate_top.sv
`timescale 1ns/10ps
`include "umi_settings.svh"

module umi_aggregate_top (
    input  logic               clk,
    input  logic               nreset,

    input  logic               umi_in_valid,
    input  logic [`UMI_CW-1:0] umi_in_cmd,
    input  logic [`UMI_AW-1:0] umi_in_dstaddr,
    input  logic [`UMI_AW-1:0] umi_in_srcaddr,
    input  logic [`UMI_DW-1:0] umi_in_data,
    output logic               umi_in_ready,

    output logic               umi_out_valid,
    output logic [`UMI_CW-1:0] umi_out_cmd,
    output logic [`UMI_AW-1:0] umi_out_dstaddr,
    output logic [`UMI_AW-1:0] umi_out_srcaddr,
    output logic [`UMI_DW-1:0] umi_out_data,
    input  logic               umi_out_ready
);

    umi_if in_if ();
    umi_if mid_if ();
    umi_if out_if ();

    assign in_if.valid   = umi_in_valid;
    assign in_if.cmd     = umi_in_cmd;
    assign in_if.dstaddr = umi_in_dstaddr;
    assign in_if.srcaddr = umi_in_srcaddr;
    assign in_if.data    = umi_in_data;
    assign umi_in_ready  = in_if.ready;

    umi_fifo i_umi_fifo (
        .clk    (clk),
        .nreset (nreset),
        .in     (in_if.snk),
        .out    (mid_if.src)
    );

    umi_data_aggregator i_umi_data_aggregator (
        .clk    (clk),
        .nreset (nreset),
        .in     (mid_if.snk),
        .out    (out_if.src)
    );

    assign umi_out_valid   = out_if.valid;
    assign umi_out_cmd     = out_if.cmd;
    assign umi_out_dstaddr = out_if.dstaddr;
    assign umi_out_srcaddr = out_if.srcaddr;
    assign umi_out_data    = out_if.data;
    assign out_if.ready    = umi_out_ready;

endmodule

//--- rtl/umi_data_aggregator.sv
`timescale 1ns/10ps
`include "umi_settings.svh"

module umi_data_aggregator (
    input logic clk,
    input logic nreset,
    umi_if.snk  in,
    umi_if.src  out
);

    localparam int CNT_W = $clog2(2 * umi_pkg::BYTES_PER_FLIT) + 1;
    localparam logic [CNT_W-1:0] FLIT_BYTES = CNT_W'(umi_pkg::BYTES_PER_FLIT);

    umi_pkg::umi_req_t     in_req;
    umi_pkg::umi_cmd_u     hdr_r;
    umi_pkg::umi_cmd_u     out_cmd;
    logic [`UMI_AW-1:0]    dst_r;
    logic [`UMI_AW-1:0]    src_r;
    logic [2*`UMI_DW-1:0]  data_r;
    logic [2*`UMI_DW-1:0]  data_next;
    logic [2*`UMI_DW-1:0]  in_data_w;
    logic [`UMI_DW-1:0]    in_mask;
    logic [15:0]           in_bytes;
    logic [CNT_W-1:0]      add_bytes;
    logic [CNT_W-1:0]      byte_cnt;
    logic [CNT_W-1:0]      cnt_next;
    logic [CNT_W-1:0]      out_bytes;

    logic first;
    logic passthrough;
    logic raw_r;
    logic eom_r;
    logic in_fire;
    logic out_fire;
    logic op_merge;
    logic fits;
    logic raw_flit;
    logic match;
    logic joins;
    logic room;

    assign in_req   = in.cmd.req;
    assign in_fire  = in.valid && in.ready;
    assign out_fire = out.valid && out.ready;

    // Opcodes that may be merged
    assign op_merge = in_req.opcode inside {umi_pkg::REQ_READ, umi_pkg::REQ_WRITE,
                                            umi_pkg::REQ_POSTED, umi_pkg::REQ_RDMA,
                                            umi_pkg::RESP_READ};

    assign in_bytes = (16'd1 << in_req.size) * (16'(in_req.len) + 16'd1);
    assign fits     = (in_bytes <= 16'(umi_pkg::BYTES_PER_FLIT));
    assign raw_flit = !op_merge || in_req.ex || !fits;

    assign match = (in_req.opcode == hdr_r.req.opcode) &&
                   (in_req.size   == hdr_r.req.size) &&
                   (in_req.qos    == hdr_r.req.qos) &&
                   (in_req.prot   == hdr_r.req.prot) &&
                   (in_req.eof    == hdr_r.req.eof) &&
                   (in_req.user   == hdr_r.req.user) &&
                   (in_req.err    == hdr_r.req.err) &&
                   (in_req.hostid == hdr_r.req.hostid) &&
                   !in_req.ex;

    assign joins = !first && !raw_flit && match;

    // Raw flits occupy a whole output flit and keep all data bits
    assign add_bytes = raw_flit ? FLIT_BYTES : in_bytes[CNT_W-1:0];
    assign in_mask   = {`UMI_DW{1'b1}} >> (8 * (FLIT_BYTES - add_bytes));
    assign in_data_w = {{`UMI_DW{1'b0}}, in.data & in_mask};

    // Above one flit, accept only while a flit leaves
    assign room     = (byte_cnt <= FLIT_BYTES) || out.ready;
    assign in.ready = !passthrough && (first || joins) && room;

    always_comb begin
        cnt_next  = byte_cnt;
        data_next = data_r;
        if (out_fire) begin
            cnt_next  = (byte_cnt > FLIT_BYTES) ? byte_cnt - FLIT_BYTES : '0;
            data_next = data_r >> `UMI_DW;
        end
        if (in_fire) begin
            if (first) begin
                data_next = in_data_w;
            end else begin
                data_next = data_next | (in_data_w << (8 * cnt_next));
            end
            cnt_next = cnt_next + add_bytes;
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            byte_cnt    <= '0;
            first       <= 1'b1;
            passthrough <= 1'b0;
            raw_r       <= 1'b0;
            eom_r       <= 1'b0;
        end else begin
            byte_cnt <= cnt_next;
            if (in_fire) begin
                first <= 1'b0;
                eom_r <= in_req.eom;
            end
            if (first && in_fire) begin
                raw_r <= raw_flit;
            end
            if (in_fire && (in_req.eom || raw_flit)) begin
                passthrough <= 1'b1;
            end else if (in.valid && !first && !passthrough && !joins) begin
                // Flit does not fit the open group
                passthrough <= 1'b1;
            end else if (passthrough && cnt_next == '0) begin
                passthrough <= 1'b0;
                first       <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        data_r <= data_next;
        if (first && in_fire) begin
            hdr_r <= in.cmd;
            dst_r <= in.dstaddr;
            src_r <= in.srcaddr;
        end
    end

    assign out_bytes = (byte_cnt > FLIT_BYTES) ? FLIT_BYTES : byte_cnt;

    always_comb begin
        out_cmd = hdr_r;
        if (!raw_r) begin
            out_cmd.req.len = 8'((out_bytes >> hdr_r.req.size) - 1'b1);
            out_cmd.req.eom = eom_r && (byte_cnt <= FLIT_BYTES);
        end
    end

    assign out.valid   = (passthrough && byte_cnt != '0) || (byte_cnt >= FLIT_BYTES);
    assign out.cmd     = out_cmd;
    assign out.dstaddr = dst_r;
    assign out.srcaddr = src_r;
    assign out.data    = data_r[`UMI_DW-1:0];

    // A stalled output flit stays put until taken
    assert property (@(posedge clk) disable iff (!nreset)
        out.valid && !out.ready |=> out.valid && $stable(out.cmd) && $stable(out.data));

    assert property (@(posedge clk) disable iff (!nreset)
        byte_cnt <= CNT_W'(2 * umi_pkg::BYTES_PER_FLIT));

endmodule

//--- rtl/umi_fifo.sv
`timescale 1ns/10ps
`include "umi_settings.svh"

module umi_fifo (
    input logic clk,
    input logic nreset,
    umi_if.snk  in,
    umi_if.src  out
);

    localparam int DEPTH = `UMI_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    umi_pkg::umi_cmd_u   cmd_mem [DEPTH];
    logic [`UMI_AW-1:0]  dst_mem [DEPTH];
    logic [`UMI_AW-1:0]  src_mem [DEPTH];
    logic [`UMI_DW-1:0]  data_mem [DEPTH];

    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                push;
    logic                pop;

    assign in.ready  = (count != CNT_W'(DEPTH));
    assign out.valid = (count != '0);
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;

    // Head of queue
    assign out.cmd     = cmd_mem[rd_ptr];
    assign out.dstaddr = dst_mem[rd_ptr];
    assign out.srcaddr = src_mem[rd_ptr];
    assign out.data    = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            cmd_mem[wr_ptr]  <= in.cmd;
            dst_mem[wr_ptr]  <= in.dstaddr;
            src_mem[wr_ptr]  <= in.srcaddr;
            data_mem[wr_ptr] <= in.data;
        end
    end

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // No push into a full buffer and no pop from an empty one
    assert property (@(posedge clk) disable iff (!nreset) count <= CNT_W'(DEPTH));

    // Pointer distance tracks the count
    assert property (@(posedge clk) disable iff (!nreset)
        (int'(wr_ptr) + DEPTH - int'(rd_ptr)) % DEPTH == int'(count) % DEPTH);

endmodule

//--- rtl/umi_if.sv
`timescale 1ns/10ps
`include "umi_settings.svh"

interface umi_if;

    logic                valid;
    umi_pkg::umi_cmd_u   cmd;
    logic [`UMI_AW-1:0]  dstaddr;
    logic [`UMI_AW-1:0]  srcaddr;
    logic [`UMI_DW-1:0]  data;
    logic                ready;

    // Flit producer
    modport src (
        output valid, cmd, dstaddr, srcaddr, data,
        input  ready
    );

    // Flit consumer
    modport snk (
        input  valid, cmd, dstaddr, srcaddr, data,
        output ready
    );

endinterface

//--- rtl/umi_pkg.sv
`include "umi_settings.svh"

package umi_pkg;

    // Data bytes carried by one flit
    localparam int BYTES_PER_FLIT = `UMI_DW / 8;

    // Opcodes seen by the aggregator
    typedef enum logic [4:0] {
        REQ_READ   = 5'd1,
        RESP_READ  = 5'd2,
        REQ_WRITE  = 5'd3,
        RESP_WRITE = 5'd4,
        REQ_POSTED = 5'd5,
        REQ_RDMA   = 5'd7,
        REQ_ATOMIC = 5'd9
    } umi_opcode_e;

    // Ordinary request and response layout
    typedef struct packed {
        logic [2:0] hostid;
        logic [1:0] err;
        logic [1:0] user;
        logic       ex;
        logic       eof;
        logic       eom;
        logic [1:0] prot;
        logic [3:0] qos;
        logic [7:0] len;
        logic [2:0] size;
        logic [4:0] opcode;
    } umi_req_t;

    // Atomic layout where bits 15:8 hold the operation type
    typedef struct packed {
        logic [2:0] hostid;
        logic [1:0] err;
        logic [1:0] user;
        logic       ex;
        logic       eof;
        logic       eom;
        logic [1:0] prot;
        logic [3:0] qos;
        logic [7:0] atype;
        logic [2:0] size;
        logic [4:0] opcode;
    } umi_atomic_t;

    // One command word, two decodings
    typedef union packed {
        umi_req_t    req;
        umi_atomic_t atomic;
    } umi_cmd_u;

endpackage

//--- include/umi_settings.svh
`ifndef UMI_SETTINGS_SVH
`define UMI_SETTINGS_SVH

// Command word width
`define UMI_CW 32

// Destination and source address width
`define UMI_AW 64

// Data width of one flit
`define UMI_DW 64

// Flits buffered ahead of the aggregator
`define UMI_FIFO_DEPTH 4

`endif
